// File: axi_adapter_top.f
rtl/axi_adapter_pkg.sv
rtl/adapter_req_if.sv
rtl/line_fill_if.sv
rtl/req_dispatch.sv
rtl/write_engine.sv
rtl/read_engine.sv
rtl/line_buffer.sv
rtl/axi_adapter_top.sv
tests/axi_mem_model.sv
tests/axi_adapter_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and judge the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module axi_adapter_tb -f axi_adapter_top.f -o axi_adapter_sim
./obj_dir/axi_adapter_sim | tee sim.log

if grep -qx "Test passed" sim.log; then
  echo "simulation result: pass"
  exit 0
else
  echo "simulation result: fail"
  exit 1
fi

// File: tests/axi_adapter_tb.sv
module axi_adapter_tb import axi_adapter_pkg::*; ();

  localparam int unsigned LINE_WORDS      = 4;
  localparam int unsigned ID_WIDTH        = 4;
  localparam int unsigned ADDR_WIDTH      = 32;
  localparam int unsigned MEM_WORDS       = 256;
  localparam int unsigned ROUNDS          = 10;
  // two writes and two reads per round
  localparam int unsigned TRANSFERS       = ROUNDS * 4;
  localparam int unsigned TRANSFER_CYCLES = 100;
  localparam int unsigned MAX_CYCLES      = TRANSFERS * TRANSFER_CYCLES;

  logic                   clk;
  logic                   reset;
  logic                   busy;
  logic                   req;
  req_type_e              kind;
  logic                   gnt;
  logic [ADDR_WIDTH-1:0]  addr;
  logic                   we;
  word_t [LINE_WORDS-1:0] wdata;
  strb_t [LINE_WORDS-1:0] be;
  size_t                  size;
  logic [ID_WIDTH-1:0]    id;
  logic                   valid;
  word_t [LINE_WORDS-1:0] rdata;
  logic [ID_WIDTH-1:0]    id_out;
  word_t                  crit_word;
  logic                   crit_valid;

  logic aw_valid, aw_ready, w_valid, w_ready, w_last, b_valid, b_ready;
  logic ar_valid, ar_ready, r_valid, r_ready, r_last;
  logic [ADDR_WIDTH-1:0] aw_addr, ar_addr;
  axi_len_t              aw_len, ar_len;
  size_t                 aw_size, ar_size;
  logic [ID_WIDTH-1:0]   aw_id, b_id, ar_id, r_id;
  word_t                 w_data, r_data;
  strb_t                 w_strb;

  int                     seed = 98861;
  int                     errors = 0;
  int                     checks = 0;
  int                     cycles = 0;
  word_t                  shadow [MEM_WORDS];
  word_t [LINE_WORDS-1:0] got_rdata;
  logic [ID_WIDTH-1:0]    got_id;
  int                     crit_count;
  word_t                  crit_seen;

  axi_adapter_top #(
    .LINE_WORDS(LINE_WORDS), .ID_WIDTH(ID_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)
  ) dut_i (
    .clk_i(clk), .reset_i(reset), .busy_o(busy), .req_i(req), .type_i(kind),
    .gnt_o(gnt), .addr_i(addr), .we_i(we), .wdata_i(wdata), .be_i(be),
    .size_i(size), .id_i(id), .valid_o(valid), .rdata_o(rdata), .id_o(id_out),
    .critical_word_o(crit_word), .critical_word_valid_o(crit_valid),
    .aw_valid_o(aw_valid), .aw_ready_i(aw_ready), .aw_addr_o(aw_addr),
    .aw_len_o(aw_len), .aw_size_o(aw_size), .aw_id_o(aw_id),
    .w_valid_o(w_valid), .w_ready_i(w_ready), .w_data_o(w_data),
    .w_strb_o(w_strb), .w_last_o(w_last),
    .b_valid_i(b_valid), .b_ready_o(b_ready), .b_id_i(b_id),
    .ar_valid_o(ar_valid), .ar_ready_i(ar_ready), .ar_addr_o(ar_addr),
    .ar_len_o(ar_len), .ar_size_o(ar_size), .ar_id_o(ar_id),
    .r_valid_i(r_valid), .r_ready_o(r_ready), .r_data_i(r_data),
    .r_id_i(r_id), .r_last_i(r_last)
  );

  axi_mem_model #(
    .LINE_WORDS(LINE_WORDS), .ID_WIDTH(ID_WIDTH), .ADDR_WIDTH(ADDR_WIDTH),
    .MEM_WORDS(MEM_WORDS)
  ) mem_i (
    .clk_i(clk), .reset_i(reset),
    .aw_valid_i(aw_valid), .aw_ready_o(aw_ready), .aw_addr_i(aw_addr), .aw_id_i(aw_id),
    .w_valid_i(w_valid), .w_ready_o(w_ready), .w_data_i(w_data), .w_strb_i(w_strb),
    .w_last_i(w_last), .b_valid_o(b_valid), .b_ready_i(b_ready), .b_id_o(b_id),
    .ar_valid_i(ar_valid), .ar_ready_o(ar_ready), .ar_addr_i(ar_addr),
    .ar_len_i(ar_len), .ar_id_i(ar_id), .r_valid_o(r_valid), .r_ready_i(r_ready),
    .r_data_o(r_data), .r_id_o(r_id), .r_last_o(r_last)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ------------------------------------------------------------
  // checking helpers
  // ------------------------------------------------------------
  task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("mismatch at %0t: %s, got %h, expected %h", $time, what, actual, expected);
    end
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("error at %0t: %s", $time, what);
  endtask

  // AXI write strobes replace only the enabled bytes
  function automatic word_t merge_bytes(word_t old, word_t data, strb_t strb);
    word_t result;
    result = old;
    for (int b = 0; b < XLEN / 8; b++) begin
      if (strb[b]) begin
        result[8*b +: 8] = data[8*b +: 8];
      end
    end
    return result;
  endfunction

  // drives one cache request and checks every cycle until valid_o
  task automatic run_transfer(input logic write, input req_type_e line_kind,
                              input logic [ADDR_WIDTH-1:0] address,
                              input logic [ID_WIDTH-1:0] tag);
    int   waited;
    int   grants;
    int   beats;
    logic done;
    logic last_beat;
    waited     = 0;
    grants     = 0;
    beats      = (line_kind == LINE_REQ) ? LINE_WORDS : 1;
    done       = 1'b0;
    last_beat  = 1'b0;
    crit_count = 0;
    @(posedge clk);
    req  <= 1'b1;
    we   <= write;
    kind <= line_kind;
    addr <= address;
    id   <= tag;
    size <= 3'd3;
    while (!done && waited < TRANSFER_CYCLES) begin
      @(posedge clk);
      // busy rises the cycle after the request is taken
      if (waited > 0) begin
        check_equal(64'(busy), 64'(1), "busy_o during transfer");
      end
      waited++;
      check_equal(64'(valid), 64'(last_beat | (b_valid & b_ready)), "valid_o timing");
      last_beat = r_valid & r_ready & r_last;
      // address beats carry the burst shape of this request
      if (aw_valid) begin
        check_equal(64'(aw_len), 64'(beats - 1), "aw_len_o");
        check_equal(64'(aw_size), 64'(size), "aw_size_o");
      end
      if (ar_valid) begin
        check_equal(64'(ar_len), 64'(beats - 1), "ar_len_o");
        check_equal(64'(ar_size), 64'(size), "ar_size_o");
      end
      if (crit_valid) begin
        crit_count++;
        crit_seen = crit_word;
      end
      if (gnt) begin
        grants++;
        req <= 1'b0;
      end
      if (valid) begin
        done = 1'b1;
        if (grants == 0) begin
          report_failure("completion arrived before any grant");
        end
        got_rdata = rdata;
        got_id    = id_out;
      end
    end
    if (!done) begin
      if (grants == 0) begin
        report_failure("request was never granted");
      end
      report_failure("transfer did not complete in time");
      req <= 1'b0;
    end
    check_equal(64'(grants), 64'(1), "grant pulses for one request");
    check_equal(64'(got_id), 64'(tag), "returned id");
  endtask

  // ------------------------------------------------------------
  // directed tests
  // ------------------------------------------------------------
  task automatic reset_outputs_low();
    @(posedge clk);
    check_equal(64'({busy, gnt, valid, crit_valid, aw_valid, w_valid, ar_valid,
                     b_ready, r_ready}), 64'(0), "outputs after reset");
  endtask

  task automatic single_write_read(input logic [ID_WIDTH-1:0] tag);
    int                    idx;
    logic [ADDR_WIDTH-1:0] address;
    word_t                 data;
    strb_t                 strb;
    idx     = $random(seed) & (MEM_WORDS - 1);
    address = ADDR_WIDTH'(idx) << WORD_BYTE_BITS;
    data    = {$random(seed), $random(seed)};
    strb    = strb_t'($random(seed));
    wdata[0] <= data;
    be[0]    <= strb;
    run_transfer(1'b1, SINGLE_REQ, address, tag);
    shadow[idx] = merge_bytes(shadow[idx], data, strb);
    run_transfer(1'b0, SINGLE_REQ, address, tag + 1'b1);
    check_equal(got_rdata[0], shadow[idx], "single read data");
    check_equal(64'(crit_count), 64'(0), "critical word on a single read");
  endtask

  task automatic line_write_read(input logic [ID_WIDTH-1:0] tag);
    int                     base;
    int                     k;
    logic [ADDR_WIDTH-1:0]  address;
    word_t [LINE_WORDS-1:0] words;
    base = ($random(seed) & (MEM_WORDS - 1)) & ~(LINE_WORDS - 1);
    for (int j = 0; j < LINE_WORDS; j++) begin
      words[j] = {$random(seed), $random(seed)};
    end
    wdata <= words;
    be    <= '1;
    run_transfer(1'b1, LINE_REQ, ADDR_WIDTH'(base) << WORD_BYTE_BITS, tag);
    for (int j = 0; j < LINE_WORDS; j++) begin
      shadow[base + j] = words[j];
    end
    // word k of the line becomes the critical word of the read back
    k       = $random(seed) & (LINE_WORDS - 1);
    address = ADDR_WIDTH'(base + k) << WORD_BYTE_BITS;
    run_transfer(1'b0, LINE_REQ, address, tag + 1'b1);
    for (int j = 0; j < LINE_WORDS; j++) begin
      check_equal(got_rdata[j], shadow[base + j], $sformatf("line read word %0d", j));
    end
    check_equal(64'(crit_count), 64'(1), "critical word pulses");
    check_equal(crit_seen, shadow[base + k], "critical word data");
  endtask

  initial begin
    req   = 1'b0;
    kind  = SINGLE_REQ;
    addr  = '0;
    we    = 1'b0;
    wdata = '0;
    be    = '0;
    size  = 3'd3;
    id    = '0;
    reset = 1'b1;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      shadow[i] = mem_i.mem[i];
    end
    reset_outputs_low();
    for (int r = 0; r < ROUNDS; r++) begin
      single_write_read(ID_WIDTH'(2 * r));
      line_write_read(ID_WIDTH'(2 * r + 8));
    end
    repeat (2) @(posedge clk);
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // watchdog over the whole run
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout after %0d cycles, the tests did not finish", cycles);
      $display("checks %0d, errors %0d", checks, errors + 1);
      $display("Test failed");
      $finish;
    end
  end

endmodule

// File: tests/axi_mem_model.sv
module axi_mem_model import axi_adapter_pkg::*; #(
  parameter int unsigned LINE_WORDS = 4,
  parameter int unsigned ID_WIDTH   = 4,
  parameter int unsigned ADDR_WIDTH = 32,
  parameter int unsigned MEM_WORDS  = 256
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  aw_valid_i,
  output logic                  aw_ready_o,
  input  logic [ADDR_WIDTH-1:0] aw_addr_i,
  input  logic [ID_WIDTH-1:0]   aw_id_i,
  input  logic                  w_valid_i,
  output logic                  w_ready_o,
  input  word_t                 w_data_i,
  input  strb_t                 w_strb_i,
  input  logic                  w_last_i,
  output logic                  b_valid_o,
  input  logic                  b_ready_i,
  output logic [ID_WIDTH-1:0]   b_id_o,
  input  logic                  ar_valid_i,
  output logic                  ar_ready_o,
  input  logic [ADDR_WIDTH-1:0] ar_addr_i,
  input  axi_len_t              ar_len_i,
  input  logic [ID_WIDTH-1:0]   ar_id_i,
  output logic                  r_valid_o,
  input  logic                  r_ready_i,
  output word_t                 r_data_o,
  output logic [ID_WIDTH-1:0]   r_id_o,
  output logic                  r_last_o
);

  localparam int unsigned IDX_W = $clog2(MEM_WORDS);

  word_t               mem [MEM_WORDS];
  // write beats wait here until the address has been taken too
  word_t               wbuf [LINE_WORDS];
  strb_t               sbuf [LINE_WORDS];
  int                  w_cnt;
  int                  seed = 98861;
  logic                aw_seen;
  logic                w_seen;
  logic [IDX_W-1:0]    aw_idx;
  logic [ID_WIDTH-1:0] aw_tag;
  logic                rd_active;
  logic [IDX_W-1:0]    rd_idx;
  axi_len_t            rd_left;
  logic [ID_WIDTH-1:0] rd_tag;

  function automatic logic [IDX_W-1:0] word_of(logic [ADDR_WIDTH-1:0] a);
    return a[WORD_BYTE_BITS +: IDX_W];
  endfunction

  initial begin
    // every word starts with a pattern built from its own index
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = {16'hc0de, 16'(i), ~16'(i), 16'(i) ^ 16'h5a5a};
    end
    aw_ready_o = 1'b0;
    w_ready_o  = 1'b0;
    ar_ready_o = 1'b0;
    b_valid_o  = 1'b0;
    b_id_o     = '0;
    r_valid_o  = 1'b0;
    r_data_o   = '0;
    r_id_o     = '0;
    r_last_o   = 1'b0;
  end

  always @(posedge clk_i) begin
    if (reset_i) begin
      aw_ready_o <= 1'b0;
      w_ready_o  <= 1'b0;
      ar_ready_o <= 1'b0;
      b_valid_o  <= 1'b0;
      r_valid_o  <= 1'b0;
      r_last_o   <= 1'b0;
      aw_seen    <= 1'b0;
      w_seen     <= 1'b0;
      w_cnt      <= 0;
      rd_active  <= 1'b0;
    end else begin
      // each ready drops in about one cycle of four
      aw_ready_o <= ($random(seed) & 3) != 0;
      w_ready_o  <= ($random(seed) & 3) != 0;
      ar_ready_o <= ($random(seed) & 3) != 0;

      if (aw_valid_i && aw_ready_o) begin
        aw_seen <= 1'b1;
        aw_idx  <= word_of(aw_addr_i);
        aw_tag  <= aw_id_i;
      end
      if (w_valid_i && w_ready_o) begin
        wbuf[w_cnt] <= w_data_i;
        sbuf[w_cnt] <= w_strb_i;
        w_cnt       <= w_cnt + 1;
        if (w_last_i) begin
          w_seen <= 1'b1;
        end
      end

      // commit the burst once address and last beat are both in
      if (aw_seen && w_seen) begin
        for (int i = 0; i < w_cnt; i++) begin
          for (int b = 0; b < XLEN / 8; b++) begin
            if (sbuf[i][b]) begin
              mem[IDX_W'(aw_idx + i)][8*b +: 8] = wbuf[i][8*b +: 8];
            end
          end
        end
        b_valid_o <= 1'b1;
        b_id_o    <= aw_tag;
        aw_seen   <= 1'b0;
        w_seen    <= 1'b0;
        w_cnt     <= 0;
      end
      if (b_valid_o && b_ready_i) begin
        b_valid_o <= 1'b0;
      end

      if (ar_valid_i && ar_ready_o && !rd_active) begin
        rd_active <= 1'b1;
        rd_idx    <= word_of(ar_addr_i);
        rd_left   <= ar_len_i;
        rd_tag    <= ar_id_i;
      end

      // incrementing beats with random gaps between them
      if (r_valid_o && r_ready_i) begin
        r_valid_o <= 1'b0;
        rd_idx    <= rd_idx + 1'b1;
        rd_left   <= rd_left - 8'd1;
        if (r_last_o) begin
          rd_active <= 1'b0;
        end
      end else if (rd_active && !r_valid_o && ($random(seed) & 3) != 0) begin
        r_valid_o <= 1'b1;
        r_data_o  <= mem[rd_idx];
        r_id_o    <= rd_tag;
        r_last_o  <= rd_left == '0;
      end
    end
  end

endmodule

// File: rtl/axi_adapter_top.sv
module axi_adapter_top import axi_adapter_pkg::*; #(
  parameter int unsigned LINE_WORDS = 4,
  parameter int unsigned ID_WIDTH   = 4,
  parameter int unsigned ADDR_WIDTH = 32
) (
  input  logic                   clk_i,
  input  logic                   reset_i,
  // cache request side
  output logic                   busy_o,
  input  logic                   req_i,
  input  req_type_e              type_i,
  output logic                   gnt_o,
  input  logic [ADDR_WIDTH-1:0]  addr_i,
  input  logic                   we_i,
  input  word_t [LINE_WORDS-1:0] wdata_i,
  input  strb_t [LINE_WORDS-1:0] be_i,
  input  size_t                  size_i,
  input  logic [ID_WIDTH-1:0]    id_i,
  output logic                   valid_o,
  output word_t [LINE_WORDS-1:0] rdata_o,
  output logic [ID_WIDTH-1:0]    id_o,
  output word_t                  critical_word_o,
  output logic                   critical_word_valid_o,
  // ------------------------------------------------------------
  // axi master side
  // ------------------------------------------------------------
  output logic                   aw_valid_o,
  input  logic                   aw_ready_i,
  output logic [ADDR_WIDTH-1:0]  aw_addr_o,
  output axi_len_t               aw_len_o,
  output size_t                  aw_size_o,
  output logic [ID_WIDTH-1:0]    aw_id_o,
  output logic                   w_valid_o,
  input  logic                   w_ready_i,
  output word_t                  w_data_o,
  output strb_t                  w_strb_o,
  output logic                   w_last_o,
  input  logic                   b_valid_i,
  output logic                   b_ready_o,
  input  logic [ID_WIDTH-1:0]    b_id_i,
  output logic                   ar_valid_o,
  input  logic                   ar_ready_i,
  output logic [ADDR_WIDTH-1:0]  ar_addr_o,
  output axi_len_t               ar_len_o,
  output size_t                  ar_size_o,
  output logic [ID_WIDTH-1:0]    ar_id_o,
  input  logic                   r_valid_i,
  output logic                   r_ready_o,
  input  word_t                  r_data_i,
  input  logic [ID_WIDTH-1:0]    r_id_i,
  input  logic                   r_last_i
);

  logic [ID_WIDTH-1:0] rd_id;

  adapter_req_if #(
    .LINE_WORDS(LINE_WORDS), .ID_WIDTH(ID_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)
  ) wr_req ();

  adapter_req_if #(
    .LINE_WORDS(LINE_WORDS), .ID_WIDTH(ID_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)
  ) rd_req ();

  line_fill_if #(.LINE_WORDS(LINE_WORDS)) fill ();

  req_dispatch #(.ID_WIDTH(ID_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)) dispatch_i (
    .clk_i, .reset_i, .req_i, .type_i, .we_i, .addr_i, .size_i, .id_i,
    .busy_o, .gnt_o, .valid_o, .id_o,
    .wr_req(wr_req.dispatch), .rd_req(rd_req.dispatch),
    .b_id_i, .rd_id_i(rd_id)
  );

  write_engine #(
    .LINE_WORDS(LINE_WORDS), .ID_WIDTH(ID_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)
  ) write_i (
    .clk_i, .reset_i, .req(wr_req.engine), .wdata_i, .be_i,
    .aw_valid_o, .aw_ready_i, .aw_addr_o, .aw_len_o, .aw_size_o, .aw_id_o,
    .w_valid_o, .w_ready_i, .w_data_o, .w_strb_o, .w_last_o,
    .b_valid_i, .b_ready_o
  );

  read_engine #(
    .LINE_WORDS(LINE_WORDS), .ID_WIDTH(ID_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)
  ) read_i (
    .clk_i, .reset_i, .req(rd_req.engine),
    .ar_valid_o, .ar_ready_i, .ar_addr_o, .ar_len_o, .ar_size_o, .ar_id_o,
    .r_valid_i, .r_ready_o, .r_data_i, .r_id_i, .r_last_i,
    .rd_id_o(rd_id), .fill(fill.filler)
  );

  line_buffer #(.LINE_WORDS(LINE_WORDS)) buffer_i (
    .clk_i, .reset_i, .fill(fill.buffer),
    .rdata_o, .critical_word_o, .critical_word_valid_o
  );

endmodule

// File: rtl/line_buffer.sv
module line_buffer import axi_adapter_pkg::*; #(
  parameter int unsigned LINE_WORDS = 4
) (
  input  logic                   clk_i,
  input  logic                   reset_i,
  line_fill_if.buffer            fill,
  output word_t [LINE_WORDS-1:0] rdata_o,
  output word_t                  critical_word_o,
  output logic                   critical_word_valid_o
);

  localparam int unsigned IDX_W = $clog2(LINE_WORDS);

  logic [IDX_W-1:0] offset_q;
  // set by a line read, cleared once its critical word has passed
  logic             armed_q;

  assign rdata_o               = fill.line;
  assign critical_word_o       = fill.fill_data;
  assign critical_word_valid_o = fill.fill & armed_q & (fill.fill_index == offset_q);

  // ------------------------------------------------------------
  // line storage and critical word tracking
  // ------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (fill.fill) begin
      fill.line[fill.fill_index] <= fill.fill_data;
    end
    if (fill.load_offset) begin
      offset_q <= fill.offset;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      armed_q <= 1'b0;
    end else if (fill.load_offset) begin
      armed_q <= 1'b1;
    end else if (critical_word_valid_o) begin
      armed_q <= 1'b0;
    end
  end

endmodule

// File: rtl/read_engine.sv
module read_engine import axi_adapter_pkg::*; #(
  parameter int unsigned LINE_WORDS = 4,
  parameter int unsigned ID_WIDTH   = 4,
  parameter int unsigned ADDR_WIDTH = 32
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  adapter_req_if.engine         req,
  output logic                  ar_valid_o,
  input  logic                  ar_ready_i,
  output logic [ADDR_WIDTH-1:0] ar_addr_o,
  output axi_len_t              ar_len_o,
  output size_t                 ar_size_o,
  output logic [ID_WIDTH-1:0]   ar_id_o,
  input  logic                  r_valid_i,
  output logic                  r_ready_o,
  input  word_t                 r_data_i,
  input  logic [ID_WIDTH-1:0]   r_id_i,
  input  logic                  r_last_i,
  output logic [ID_WIDTH-1:0]   rd_id_o,
  line_fill_if.filler           fill
);

  localparam int unsigned IDX_W    = $clog2(LINE_WORDS);
  localparam int unsigned LINE_OFF = WORD_BYTE_BITS + IDX_W;

  read_state_e         state_q, state_d;
  // index of the next beat within the line
  logic [IDX_W-1:0]    cnt_q, cnt_d;
  logic [ID_WIDTH-1:0] id_q, id_d;

  // line reads start at the aligned base, single reads at the exact address
  assign ar_addr_o = (req.line == LINE_REQ) ? {req.addr[ADDR_WIDTH-1:LINE_OFF], {LINE_OFF{1'b0}}}
                                            : req.addr;
  assign ar_len_o  = req.len;
  assign ar_size_o = req.size;
  assign ar_id_o   = req.id;
  assign rd_id_o   = id_q;

  assign fill.offset     = req.addr[WORD_BYTE_BITS +: IDX_W];
  assign fill.fill_data  = r_data_i;
  assign fill.fill_index = (state_q == WAIT_R_VALID_MULTIPLE) ? cnt_q : '0;

  always_comb begin
    ar_valid_o       = 1'b0;
    r_ready_o        = 1'b0;
    fill.load_offset = 1'b0;
    fill.fill        = 1'b0;
    req.gnt          = 1'b0;
    req.done         = 1'b0;
    state_d          = state_q;
    cnt_d            = cnt_q;
    id_d             = id_q;

    case (state_q)
      RD_IDLE: begin
        cnt_d = '0;
        if (req.start) begin
          ar_valid_o = 1'b1;
          req.gnt    = ar_ready_i;
          if (ar_ready_i) begin
            fill.load_offset = req.line == LINE_REQ;
            state_d = (req.line == LINE_REQ) ? WAIT_R_VALID_MULTIPLE : WAIT_R_VALID;
          end
        end
      end

      WAIT_R_VALID, WAIT_R_VALID_MULTIPLE: begin
        r_ready_o = 1'b1;
        if (r_valid_i) begin
          fill.fill = 1'b1;
          cnt_d     = cnt_q + 1'b1;
          if (r_last_i) begin
            id_d    = r_id_i;
            state_d = COMPLETE_READ;
          end
        end
      end

      // line register now holds the last beat
      COMPLETE_READ: begin
        req.done = 1'b1;
        state_d  = RD_IDLE;
      end

      default: state_d = RD_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= RD_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
    id_q <= id_d;
  end

endmodule

// File: rtl/write_engine.sv
module write_engine import axi_adapter_pkg::*; #(
  parameter int unsigned LINE_WORDS = 4,
  parameter int unsigned ID_WIDTH   = 4,
  parameter int unsigned ADDR_WIDTH = 32
) (
  input  logic                   clk_i,
  input  logic                   reset_i,
  adapter_req_if.engine          req,
  input  word_t [LINE_WORDS-1:0] wdata_i,
  input  strb_t [LINE_WORDS-1:0] be_i,
  output logic                   aw_valid_o,
  input  logic                   aw_ready_i,
  output logic [ADDR_WIDTH-1:0]  aw_addr_o,
  output axi_len_t               aw_len_o,
  output size_t                  aw_size_o,
  output logic [ID_WIDTH-1:0]    aw_id_o,
  output logic                   w_valid_o,
  input  logic                   w_ready_i,
  output word_t                  w_data_o,
  output strb_t                  w_strb_o,
  output logic                   w_last_o,
  input  logic                   b_valid_i,
  output logic                   b_ready_o
);

  localparam int unsigned BURST = LINE_WORDS - 1;
  localparam int unsigned CNT_W = $clog2(LINE_WORDS);

  write_state_e     state_q, state_d;
  // beats still to send after the current one
  logic [CNT_W-1:0] cnt_q, cnt_d;
  logic [CNT_W-1:0] beat_idx;

  assign aw_addr_o = req.addr;
  assign aw_len_o  = req.len;
  assign aw_size_o = req.size;
  assign aw_id_o   = req.id;

  // first beat is always word 0, a single write never moves past it
  assign beat_idx = (state_q == WR_IDLE || req.line == SINGLE_REQ) ? '0
                                                                   : CNT_W'(BURST) - cnt_q;
  assign w_data_o = wdata_i[beat_idx];
  assign w_strb_o = be_i[beat_idx];

  always_comb begin
    aw_valid_o = 1'b0;
    w_valid_o  = 1'b0;
    w_last_o   = 1'b0;
    b_ready_o  = 1'b0;
    req.gnt    = 1'b0;
    req.done   = 1'b0;
    state_d    = state_q;
    cnt_d      = cnt_q;

    case (state_q)
      WR_IDLE: begin
        cnt_d = '0;
        if (req.start) begin
          // address and first beat go out together
          aw_valid_o = 1'b1;
          w_valid_o  = 1'b1;
          if (req.line == SINGLE_REQ) begin
            w_last_o = 1'b1;
            req.gnt  = aw_ready_i & w_ready_i;
            case ({aw_ready_i, w_ready_i})
              2'b11:   state_d = WAIT_B_VALID;
              2'b01:   state_d = WAIT_AW_READY;
              2'b10:   state_d = WAIT_LAST_W_READY;
              default: state_d = WR_IDLE;
            endcase
          end else begin
            cnt_d = w_ready_i ? CNT_W'(BURST - 1) : CNT_W'(BURST);
            case ({aw_ready_i, w_ready_i})
              2'b11:   state_d = WAIT_LAST_W_READY;
              2'b01:   state_d = WAIT_LAST_W_READY_AW_READY;
              2'b10:   state_d = WAIT_LAST_W_READY;
              default: state_d = WR_IDLE;
            endcase
          end
        end
      end

      // single write, data taken, address still pending
      WAIT_AW_READY: begin
        aw_valid_o = 1'b1;
        if (aw_ready_i) begin
          req.gnt = 1'b1;
          state_d = WAIT_B_VALID;
        end
      end

      // burst with both address and data beats outstanding
      WAIT_LAST_W_READY_AW_READY: begin
        aw_valid_o = 1'b1;
        w_valid_o  = 1'b1;
        w_last_o   = cnt_q == '0;
        case ({aw_ready_i, w_ready_i})
          2'b01: begin
            if (cnt_q == '0) begin
              state_d = WAIT_AW_READY_BURST;
            end else begin
              cnt_d = cnt_q - 1'b1;
            end
          end
          2'b10: state_d = WAIT_LAST_W_READY;
          2'b11: begin
            if (cnt_q == '0) begin
              req.gnt = 1'b1;
              state_d = WAIT_B_VALID;
            end else begin
              cnt_d   = cnt_q - 1'b1;
              state_d = WAIT_LAST_W_READY;
            end
          end
          default: state_d = state_q;
        endcase
      end

      // all data sent, burst address pending
      WAIT_AW_READY_BURST: begin
        aw_valid_o = 1'b1;
        if (aw_ready_i) begin
          req.gnt = 1'b1;
          state_d = WAIT_B_VALID;
        end
      end

      WAIT_LAST_W_READY: begin
        w_valid_o = 1'b1;
        if (cnt_q == '0) begin
          w_last_o = 1'b1;
          if (w_ready_i) begin
            req.gnt = 1'b1;
            state_d = WAIT_B_VALID;
          end
        end else if (w_ready_i) begin
          cnt_d = cnt_q - 1'b1;
        end
      end

      WAIT_B_VALID: begin
        if (b_valid_i) begin
          b_ready_o = 1'b1;
          req.done  = 1'b1;
          state_d   = WR_IDLE;
        end
      end

      default: state_d = WR_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= WR_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

endmodule

// File: rtl/req_dispatch.sv
module req_dispatch import axi_adapter_pkg::*; #(
  parameter int unsigned ID_WIDTH   = 4,
  parameter int unsigned ADDR_WIDTH = 32
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  req_i,
  input  req_type_e             type_i,
  input  logic                  we_i,
  input  logic [ADDR_WIDTH-1:0] addr_i,
  input  size_t                 size_i,
  input  logic [ID_WIDTH-1:0]   id_i,
  output logic                  busy_o,
  output logic                  gnt_o,
  output logic                  valid_o,
  output logic [ID_WIDTH-1:0]   id_o,
  adapter_req_if.dispatch       wr_req,
  adapter_req_if.dispatch       rd_req,
  input  logic [ID_WIDTH-1:0]   b_id_i,
  input  logic [ID_WIDTH-1:0]   rd_id_i
);

  dispatch_state_e state_q;
  logic            granted_q;

  // request fields go to both engines, only start selects one
  assign wr_req.line = type_i;
  assign wr_req.addr = addr_i;
  assign wr_req.size = size_i;
  assign wr_req.id   = id_i;
  assign rd_req.line = type_i;
  assign rd_req.addr = addr_i;
  assign rd_req.size = size_i;
  assign rd_req.id   = id_i;

  // start is offered in the request cycle and held until granted
  assign wr_req.start = we_i & ((state_q == DISP_IDLE & req_i) |
                                (state_q == DISP_WRITE & ~granted_q));
  assign rd_req.start = ~we_i & ((state_q == DISP_IDLE & req_i) |
                                 (state_q == DISP_READ & ~granted_q));

  assign gnt_o   = wr_req.gnt | rd_req.gnt;
  assign valid_o = wr_req.done | rd_req.done;
  assign busy_o  = state_q != DISP_IDLE;
  // write id comes straight off the b channel, read id was latched on r_last
  assign id_o    = (state_q == DISP_READ) ? rd_id_i : b_id_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q   <= DISP_IDLE;
      granted_q <= 1'b0;
    end else begin
      case (state_q)
        DISP_IDLE: begin
          if (req_i) begin
            state_q   <= we_i ? DISP_WRITE : DISP_READ;
            granted_q <= gnt_o;
          end
        end
        default: begin
          if (gnt_o) begin
            granted_q <= 1'b1;
          end
          if (valid_o) begin
            state_q   <= DISP_IDLE;
            granted_q <= 1'b0;
          end
        end
      endcase
    end
  end

endmodule

// File: rtl/line_fill_if.sv
interface line_fill_if import axi_adapter_pkg::*; #(
  parameter int unsigned LINE_WORDS = 4
) ();

  localparam int unsigned IDX_W = $clog2(LINE_WORDS);

  logic                      load_offset;
  logic [IDX_W-1:0]          offset;
  logic                      fill;
  logic [IDX_W-1:0]          fill_index;
  word_t                     fill_data;
  // the cache line itself, held by the buffer
  word_t [LINE_WORDS-1:0]    line;

  modport filler (output load_offset, offset, fill, fill_index, fill_data);

  modport buffer (input load_offset, offset, fill, fill_index, fill_data, output line);

endinterface

// File: rtl/adapter_req_if.sv
interface adapter_req_if import axi_adapter_pkg::*; #(
  parameter int unsigned LINE_WORDS = 4,
  parameter int unsigned ID_WIDTH   = 4,
  parameter int unsigned ADDR_WIDTH = 32
) ();

  logic                  start;
  req_type_e             line;
  logic [ADDR_WIDTH-1:0] addr;
  size_t                 size;
  logic [ID_WIDTH-1:0]   id;
  axi_len_t              len;
  logic                  gnt;
  logic                  done;

  // burst length follows the request type
  assign len = (line == LINE_REQ) ? axi_len_t'(LINE_WORDS - 1) : LEN_SINGLE;

  modport dispatch (output start, line, addr, size, id, input gnt, done);

  modport engine (input start, line, addr, size, id, len, output gnt, done);

endinterface

// File: rtl/axi_adapter_pkg.sv
package axi_adapter_pkg;

  // one data word of the cache interface
  localparam int unsigned XLEN = 64;

  // low address bits that select a byte inside one word
  localparam int unsigned WORD_BYTE_BITS = 3;

  typedef logic [XLEN-1:0]   word_t;
  typedef logic [XLEN/8-1:0] strb_t;

  // axi size code of one beat: 1, 2, 4 or 8 bytes
  typedef logic [2:0] size_t;

  // axi burst length, beats minus one
  typedef logic [7:0] axi_len_t;

  // length code of a one-beat transfer
  localparam axi_len_t LEN_SINGLE = 8'd0;

  typedef enum logic {SINGLE_REQ, LINE_REQ} req_type_e;

  typedef enum logic [1:0] {DISP_IDLE, DISP_WRITE, DISP_READ} dispatch_state_e;

  typedef enum logic [2:0] {
    WR_IDLE,
    WAIT_AW_READY,
    WAIT_LAST_W_READY,
    WAIT_LAST_W_READY_AW_READY,
    WAIT_AW_READY_BURST,
    WAIT_B_VALID
  } write_state_e;

  typedef enum logic [1:0] {RD_IDLE, WAIT_R_VALID, WAIT_R_VALID_MULTIPLE, COMPLETE_READ} read_state_e;

endpackage
